// ==== source/cabinet_pkg.sv ====
// Control-path definitions for the cabinet logic: game codes, download indices and joystick bits
package cabinet_pkg;

	// ========================================================================
	// Game selection
	// ========================================================================

	// Code written to download index 1 by the loader
	typedef enum logic [1:0] {
		GAME_TAPPER  = 2'd0,
		GAME_TIMBER  = 2'd1,
		GAME_DOTRON  = 2'd2,
		GAME_JOURNEY = 2'd3
	} game_t;

	// ========================================================================
	// Download stream
	// ========================================================================

	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_GAME = 8'd1;
	localparam logic [7:0] IDX_DIP  = 8'd254;

	localparam int IOCTL_ADDR_W = 25;

	// ========================================================================
	// Joystick words and board ports
	// ========================================================================

	localparam int JOY_W = 16;

	// Bit positions inside one player joystick word
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	// Bits 8 and 9 carry the rotate buttons, unused here
	localparam int JOY_START1 = 10;
	localparam int JOY_START2 = 11;
	localparam int JOY_COIN   = 12;

	// DIP switch bytes loaded at index 254
	localparam int DIP_BANKS = 8;

	// One active-low board input port
	typedef logic [7:0] port_byte_t;

endpackage

// ==== source/audio_pkg.sv ====
// Audio-path definitions shared by the mixer and its testbench: sample type and clamp limits
package audio_pkg;

	// Board and PCM samples are two's complement
	typedef logic signed [15:0] sample_t;

	// Saturation limits for the Journey blend
	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage

// ==== source/download_decoder.sv ====
// Download stage; routes indexed ioctl bytes to the ROM write port, game register and DIP bank
module download_decoder #(
	parameter int ROM_ADDR_W = 16
) (
	input  logic                                  clk_sys,
	input  logic                                  rst_n,
	input  logic                                  ioctl_download,
	input  logic                                  ioctl_wr,
	input  logic [7:0]                            ioctl_index,
	input  logic [cabinet_pkg::IOCTL_ADDR_W-1:0]  ioctl_addr,
	input  logic [7:0]                            ioctl_dout,
	output logic                                  rom_we,
	output logic [ROM_ADDR_W-1:0]                 rom_waddr,
	output logic [7:0]                            rom_wdata,
	output cabinet_pkg::game_t                    game,
	output cabinet_pkg::port_byte_t               dip_bank [cabinet_pkg::DIP_BANKS],
	output logic                                  rom_loading,
	output logic                                  rom_loaded
);
	import cabinet_pkg::*;

	localparam int DIP_SEL_W = $clog2(DIP_BANKS);

	logic rom_hit;
	logic loading_q;
	logic load_done;

	// ROM transfer in progress, seen by the reset sequencer without delay
	assign rom_loading = ioctl_download && (ioctl_index == IDX_ROM);

	// Writes beyond the ROM size are dropped
	assign rom_hit = (ioctl_addr[IOCTL_ADDR_W-1:ROM_ADDR_W] == '0);

	// ========================================================================
	// Program ROM write port
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rom_we <= 1'b0;
		end else begin
			rom_we <= ioctl_wr && rom_loading && rom_hit;
		end
	end

	always_ff @(posedge clk_sys) begin
		rom_waddr <= ioctl_addr[ROM_ADDR_W-1:0];
		rom_wdata <= ioctl_dout;
	end

	// ========================================================================
	// Game select and DIP switches
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			game     <= GAME_TAPPER;
			dip_bank <= '{default: 8'hff};
		end else if (ioctl_wr) begin
			// Codes above 3 are not a known game, keep the current one
			if (ioctl_index == IDX_GAME && ioctl_dout[7:2] == '0)
				game <= game_t'(ioctl_dout[1:0]);
			if (ioctl_index == IDX_DIP && ioctl_addr < IOCTL_ADDR_W'(DIP_BANKS))
				dip_bank[ioctl_addr[DIP_SEL_W-1:0]] <= ioctl_dout;
		end
	end

	// End of ROM load, two stages after the level drops
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			loading_q  <= 1'b0;
			load_done  <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			loading_q  <= rom_loading;
			load_done  <= loading_q && !rom_loading;
			rom_loaded <= rom_loaded || load_done;
		end
	end

	// Once loaded, the board keeps its ROM until the next reset
	a_loaded_sticky: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n) |-> !$fell(rom_loaded))
		else $error("rom_loaded fell outside reset");

endmodule

// ==== source/program_rom.sv ====
// Main CPU program ROM; written by the download stage and read synchronously by the board
module program_rom #(
	parameter int ROM_ADDR_W = 16
) (
	input  logic                  clk_sys,
	input  logic                  we,
	input  logic [ROM_ADDR_W-1:0] waddr,
	input  logic [7:0]            wdata,
	input  logic [ROM_ADDR_W-1:0] raddr,
	output logic [7:0]            rdata
);

	localparam int DEPTH = 2 ** ROM_ADDR_W;

	logic [7:0] mem [DEPTH];

	// Download side
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Board side, data one cycle after the address
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== source/reset_sequencer.sv ====
// Board reset generation; holds reset until the ROM is loaded and then adds one late pulse
module reset_sequencer #(
	parameter int unsigned RESET_HOLD = 65535
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic reset_request,
	input  logic rom_loading,
	input  logic rom_loaded,
	output logic core_reset
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic             cause;
	logic [CNT_W-1:0] hold_count;

	// Anything that keeps the board from running
	assign cause = reset_request || rom_loading || !rom_loaded;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hold_count <= CNT_W'(RESET_HOLD);
			core_reset <= 1'b1;
		end else begin
			// Restart the countdown while any cause is present
			if (cause)
				hold_count <= CNT_W'(RESET_HOLD);
			else if (hold_count != '0)
				hold_count <= hold_count - 1'b1;

			// Second pulse once the board has been running for a while
			core_reset <= cause || (hold_count == CNT_W'(1));
		end
	end

	// No board activity before the download stage reports a full ROM
	a_hold_until_loaded: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!rom_loaded |=> core_reset)
		else $error("core_reset low after rom_loaded was low");

endmodule

// ==== source/control_mapper.sv ====
// Player controls to board input ports; per-game layouts, registered and active low
module control_mapper (
	input  logic                           clk_sys,
	input  logic                           rst_n,
	input  logic [cabinet_pkg::JOY_W-1:0]  joystick_1,
	input  logic [cabinet_pkg::JOY_W-1:0]  joystick_2,
	input  cabinet_pkg::game_t             game,
	input  cabinet_pkg::port_byte_t        dip_bank [cabinet_pkg::DIP_BANKS],
	output cabinet_pkg::port_byte_t        input_0,
	output cabinet_pkg::port_byte_t        input_1,
	output cabinet_pkg::port_byte_t        input_2,
	output cabinet_pkg::port_byte_t        input_3,
	output logic                           landscape
);
	import cabinet_pkg::*;

	logic [JOY_W-1:0] joy;
	logic             service;
	logic             start1;
	logic             start2;
	logic             coin;
	port_byte_t       next_0;
	port_byte_t       next_1;
	port_byte_t       next_2;
	logic             next_landscape;

	// ========================================================================
	// Combined controls
	// ========================================================================

	assign joy     = joystick_1 | joystick_2;
	assign service = dip_bank[1][0];
	assign start1  = joy[JOY_START1];
	assign start2  = joy[JOY_START2];
	// Dotron also takes a coin from either start button
	assign coin    = joy[JOY_COIN] || ((game == GAME_DOTRON) && (start1 || start2));

	// ========================================================================
	// Per-game port layout
	// ========================================================================

	always_comb begin
		next_landscape = 1'b1;
		next_0 = ~{service, 3'b000, start2, start1, 1'b0, coin};
		next_1 = ~{3'b000, joy[JOY_FIRE_A], joy[JOY_UP], joy[JOY_DOWN],
			joy[JOY_LEFT], joy[JOY_RIGHT]};
		next_2 = next_1;

		case (game)
			GAME_TIMBER: begin
				// Separate controls for each player
				next_1 = ~{2'b00, joystick_1[JOY_FIRE_A], joystick_1[JOY_FIRE_B],
					joystick_1[JOY_UP], joystick_1[JOY_DOWN],
					joystick_1[JOY_LEFT], joystick_1[JOY_RIGHT]};
				next_2 = ~{2'b00, joystick_2[JOY_FIRE_A], joystick_2[JOY_FIRE_B],
					joystick_2[JOY_UP], joystick_2[JOY_DOWN],
					joystick_2[JOY_LEFT], joystick_2[JOY_RIGHT]};
			end
			GAME_DOTRON: begin
				next_0 = ~{service, 2'b00, joy[JOY_FIRE_A], start2, start1, 1'b0, coin};
				// Spinner port, idle
				next_1 = ~8'h00;
				next_2 = ~{1'b0, joy[JOY_FIRE_B], joy[JOY_FIRE_C], joy[JOY_FIRE_D],
					joy[JOY_DOWN], joy[JOY_UP], joy[JOY_RIGHT], joy[JOY_LEFT]};
			end
			GAME_JOURNEY: begin
				next_landscape = 1'b0;
				next_0 = ~{service, 2'b00, joy[JOY_FIRE_A], start2, start1, 1'b0, coin};
				next_1 = ~{4'b0000, joy[JOY_DOWN], joy[JOY_UP], joy[JOY_RIGHT],
					joy[JOY_LEFT]};
				next_2 = ~{3'b000, joy[JOY_FIRE_A], joy[JOY_DOWN], joy[JOY_UP],
					joy[JOY_RIGHT], joy[JOY_LEFT]};
			end
			default: begin
				// Tapper layout as set above
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			input_0   <= 8'hff;
			input_1   <= 8'hff;
			input_2   <= 8'hff;
			input_3   <= 8'hff;
			landscape <= 1'b1;
		end else begin
			input_0   <= next_0;
			input_1   <= next_1;
			input_2   <= next_2;
			// DIP bytes arrive in board polarity already
			input_3   <= dip_bank[0];
			landscape <= next_landscape;
		end
	end

	// DIP byte 0 reaches the board unchanged one cycle after the download stage
	a_dip_port: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n) |-> input_3 == $past(dip_bank[0]))
		else $error("input_3 does not follow DIP byte 0");

endmodule

// ==== source/audio_mixer.sv ====
// Board audio output stage; pass-through, or saturating PCM blend for Journey
module audio_mixer (
	input  logic                 clk_sys,
	input  logic                 rst_n,
	input  cabinet_pkg::game_t   game,
	input  audio_pkg::sample_t   board_l,
	input  audio_pkg::sample_t   board_r,
	input  audio_pkg::sample_t   wav_pcm,
	output audio_pkg::sample_t   audio_l,
	output audio_pkg::sample_t   audio_r,
	output logic                 audio_signed
);
	import cabinet_pkg::*;
	import audio_pkg::*;

	logic    journey;
	sample_t mix_l;
	sample_t mix_r;

	// Board sample plus half the PCM track, clamped on overflow
	function automatic sample_t mix_sample(input sample_t board, input sample_t pcm);
		sample_t     half;
		logic [16:0] sum;
		half = pcm >>> 1;
		sum  = {board[15], board} + {half[15], half};
		if (sum[16] != sum[15])
			return sum[16] ? SAMPLE_MIN : SAMPLE_MAX;
		return sample_t'(sum[15:0]);
	endfunction

	assign journey = (game == GAME_JOURNEY);
	assign mix_l   = mix_sample(board_l, wav_pcm);
	assign mix_r   = mix_sample(board_r, wav_pcm);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			audio_l      <= '0;
			audio_r      <= '0;
			audio_signed <= 1'b0;
		end else begin
			audio_l      <= journey ? mix_l : board_l;
			audio_r      <= journey ? mix_r : board_r;
			audio_signed <= journey;
		end
	end

endmodule

// ==== source/mcr3_cabinet.sv ====
// Top level of the cabinet glue logic; connects download, ROM, reset, controls and audio
module mcr3_cabinet #(
	parameter int          ROM_ADDR_W = 16,
	parameter int unsigned RESET_HOLD = 65535
) (
	input  logic                                 clk_sys,
	input  logic                                 rst_n,
	input  logic                                 ioctl_download,
	input  logic                                 ioctl_wr,
	input  logic [7:0]                           ioctl_index,
	input  logic [cabinet_pkg::IOCTL_ADDR_W-1:0] ioctl_addr,
	input  logic [7:0]                           ioctl_dout,
	input  logic                                 reset_request,
	input  logic [cabinet_pkg::JOY_W-1:0]        joystick_1,
	input  logic [cabinet_pkg::JOY_W-1:0]        joystick_2,
	input  logic [ROM_ADDR_W-1:0]                rom_addr,
	input  audio_pkg::sample_t                   board_l,
	input  audio_pkg::sample_t                   board_r,
	input  audio_pkg::sample_t                   wav_pcm,
	output logic [7:0]                           rom_data,
	output logic                                 core_reset,
	output cabinet_pkg::port_byte_t              input_0,
	output cabinet_pkg::port_byte_t              input_1,
	output cabinet_pkg::port_byte_t              input_2,
	output cabinet_pkg::port_byte_t              input_3,
	output logic                                 landscape,
	output audio_pkg::sample_t                   audio_l,
	output audio_pkg::sample_t                   audio_r,
	output logic                                 audio_signed
);
	import cabinet_pkg::*;

	logic                  rom_we;
	logic [ROM_ADDR_W-1:0] rom_waddr;
	logic [7:0]            rom_wdata;
	game_t                 game;
	port_byte_t            dip_bank [DIP_BANKS];
	logic                  rom_loading;
	logic                  rom_loaded;

	download_decoder #(.ROM_ADDR_W(ROM_ADDR_W)) download_decoder_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.rom_we         (rom_we),
		.rom_waddr      (rom_waddr),
		.rom_wdata      (rom_wdata),
		.game           (game),
		.dip_bank       (dip_bank),
		.rom_loading    (rom_loading),
		.rom_loaded     (rom_loaded)
	);

	program_rom #(.ROM_ADDR_W(ROM_ADDR_W)) program_rom_inst (
		.clk_sys (clk_sys),
		.we      (rom_we),
		.waddr   (rom_waddr),
		.wdata   (rom_wdata),
		.raddr   (rom_addr),
		.rdata   (rom_data)
	);

	reset_sequencer #(.RESET_HOLD(RESET_HOLD)) reset_sequencer_inst (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.reset_request (reset_request),
		.rom_loading   (rom_loading),
		.rom_loaded    (rom_loaded),
		.core_reset    (core_reset)
	);

	control_mapper control_mapper_inst (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.joystick_1 (joystick_1),
		.joystick_2 (joystick_2),
		.game       (game),
		.dip_bank   (dip_bank),
		.input_0    (input_0),
		.input_1    (input_1),
		.input_2    (input_2),
		.input_3    (input_3),
		.landscape  (landscape)
	);

	audio_mixer audio_mixer_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.game         (game),
		.board_l      (board_l),
		.board_r      (board_r),
		.wav_pcm      (wav_pcm),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.audio_signed (audio_signed)
	);

endmodule

// ==== tb/tb_mcr3_cabinet.sv ====
// Testbench for the cabinet top level; drives downloads, controls and audio, checks with assertions
module tb_mcr3_cabinet;
	timeunit 1ns;
	timeprecision 1ps;
	import cabinet_pkg::*;
	import audio_pkg::*;

	localparam int ROM_ADDR_W = 10;
	localparam int RESET_HOLD = 40;
	localparam int ROM_BYTES  = 64;
	localparam int CYCLE_LIMIT = 4000;

	logic clk_sys;
	logic rst_n;
	logic ioctl_download;
	logic ioctl_wr;
	logic [7:0] ioctl_index;
	logic [IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [7:0] ioctl_dout;
	logic reset_request;
	logic [JOY_W-1:0] joystick_1;
	logic [JOY_W-1:0] joystick_2;
	logic [ROM_ADDR_W-1:0] rom_addr;
	sample_t board_l;
	sample_t board_r;
	sample_t wav_pcm;
	logic [7:0] rom_data;
	logic core_reset;
	port_byte_t input_0;
	port_byte_t input_1;
	port_byte_t input_2;
	port_byte_t input_3;
	logic landscape;
	sample_t audio_l;
	sample_t audio_r;
	logic audio_signed;

	integer seed = 32'he6df;
	int error_count = 0;
	int cycle_count = 0;

	// Reference state built from the stimulus alone
	logic [7:0] ref_mem [2 ** ROM_ADDR_W];
	logic       ref_val [2 ** ROM_ADDR_W];
	logic       wr_pend;
	logic [ROM_ADDR_W-1:0] wr_addr;
	logic [7:0] wr_data;
	logic [1:0] ref_game;
	logic [7:0] ref_dip [DIP_BANKS];
	logic       ref_loading;
	logic       loading_d;
	logic       done_d;
	logic       ref_loaded;
	logic       ref_cause;
	int         since_clear;
	int         pulse_count;
	logic [24:0] exp_ports;
	logic [32:0] exp_audio;

	mcr3_cabinet #(.ROM_ADDR_W(ROM_ADDR_W), .RESET_HOLD(RESET_HOLD)) mcr3_cabinet_inst (
		.clk_sys(clk_sys), .rst_n(rst_n), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .reset_request(reset_request),
		.joystick_1(joystick_1), .joystick_2(joystick_2), .rom_addr(rom_addr),
		.board_l(board_l), .board_r(board_r), .wav_pcm(wav_pcm),
		.rom_data(rom_data), .core_reset(core_reset), .input_0(input_0),
		.input_1(input_1), .input_2(input_2), .input_3(input_3),
		.landscape(landscape), .audio_l(audio_l), .audio_r(audio_r),
		.audio_signed(audio_signed)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic report_error(input string msg);
		error_count++;
		$display("ERROR at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1, "first check failure");
	endtask

	// Port layout per game, taken from the board table
	function automatic logic [24:0] expected_ports(input logic [1:0] g, input logic [15:0] j1,
		input logic [15:0] j2, input logic svc);
		logic [15:0] j;
		logic [7:0] p0;
		logic [7:0] p1;
		logic [7:0] p2;
		logic land;
		j = j1 | j2;
		p0 = '0;
		p1 = '0;
		p2 = '0;
		land = 1'b1;
		p0[7] = svc;
		p0[3] = j[JOY_START2];
		p0[2] = j[JOY_START1];
		p0[0] = j[JOY_COIN];
		if (g == 2'd1) begin
			p1 = {2'b00, j1[JOY_FIRE_A], j1[JOY_FIRE_B], j1[JOY_UP], j1[JOY_DOWN],
				j1[JOY_LEFT], j1[JOY_RIGHT]};
			p2 = {2'b00, j2[JOY_FIRE_A], j2[JOY_FIRE_B], j2[JOY_UP], j2[JOY_DOWN],
				j2[JOY_LEFT], j2[JOY_RIGHT]};
		end else if (g == 2'd2) begin
			p0[4] = j[JOY_FIRE_A];
			p0[0] = j[JOY_COIN] | j[JOY_START1] | j[JOY_START2];
			p2 = {1'b0, j[JOY_FIRE_B], j[JOY_FIRE_C], j[JOY_FIRE_D], j[JOY_DOWN],
				j[JOY_UP], j[JOY_RIGHT], j[JOY_LEFT]};
		end else if (g == 2'd3) begin
			p0[4] = j[JOY_FIRE_A];
			land = 1'b0;
			p1 = {4'h0, j[JOY_DOWN], j[JOY_UP], j[JOY_RIGHT], j[JOY_LEFT]};
			p2 = {3'b000, j[JOY_FIRE_A], j[JOY_DOWN], j[JOY_UP], j[JOY_RIGHT], j[JOY_LEFT]};
		end else begin
			p1 = {3'b000, j[JOY_FIRE_A], j[JOY_UP], j[JOY_DOWN], j[JOY_LEFT], j[JOY_RIGHT]};
			p2 = p1;
		end
		return {land, ~p0, ~p1, ~p2};
	endfunction

	// Board plus half PCM in wide integers, then clamped
	function automatic logic [15:0] blend(input logic signed [15:0] b,
		input logic signed [15:0] p);
		int sum;
		sum = int'(b) + (int'(p) >>> 1);
		if (sum > 32767)
			sum = 32767;
		if (sum < -32768)
			sum = -32768;
		return sum[15:0];
	endfunction

	// ========================================================================
	// Reference models
	// ========================================================================

	assign ref_loading = ioctl_download && (ioctl_index == 8'd0);
	assign ref_cause   = reset_request || ref_loading || !ref_loaded;
	assign exp_ports   = expected_ports(ref_game, joystick_1, joystick_2, ref_dip[1][0]);
	assign exp_audio   = (ref_game == 2'd3) ?
		{1'b1, blend(board_l, wav_pcm), blend(board_r, wav_pcm)} : {1'b0, board_l, board_r};

	always @(posedge clk_sys) begin
		if (!rst_n) begin
			for (int i = 0; i < 2 ** ROM_ADDR_W; i++)
				ref_val[i] <= 1'b0;
			wr_pend <= 1'b0;
			ref_game <= 2'd0;
			for (int i = 0; i < DIP_BANKS; i++)
				ref_dip[i] <= 8'hff;
			loading_d <= 1'b0;
			done_d <= 1'b0;
			ref_loaded <= 1'b0;
			since_clear <= 0;
			pulse_count <= 0;
		end else begin
			// ROM write lands one cycle after its strobe
			wr_pend <= ioctl_wr && ref_loading && ioctl_addr < 2 ** ROM_ADDR_W;
			wr_addr <= ioctl_addr[ROM_ADDR_W-1:0];
			wr_data <= ioctl_dout;
			if (wr_pend) begin
				ref_mem[wr_addr] <= wr_data;
				ref_val[wr_addr] <= 1'b1;
			end
			if (ioctl_wr && ioctl_index == 8'd1 && ioctl_dout < 8'd4)
				ref_game <= ioctl_dout[1:0];
			if (ioctl_wr && ioctl_index == 8'd254 && ioctl_addr < DIP_BANKS)
				ref_dip[ioctl_addr[2:0]] <= ioctl_dout;
			loading_d <= ref_loading;
			done_d <= loading_d && !ref_loading;
			ref_loaded <= ref_loaded || done_d;
			since_clear <= ref_cause ? 0 : since_clear + 1;
			if (ref_cause)
				pulse_count <= 0;
			else if (core_reset && since_clear >= 2)
				pulse_count <= pulse_count + 1;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	// ========================================================================
	// Checks
	// ========================================================================

	a_hold: assert property (@(posedge clk_sys) disable iff (!rst_n) ref_cause |=> core_reset)
		else report_error("core_reset low while a reset cause was present");
	a_window: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(core_reset && !ref_cause && since_clear >= 2) |->
		(since_clear >= RESET_HOLD - 2 && since_clear <= RESET_HOLD + 2))
		else report_error("late reset pulse outside its window");
	a_one_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(since_clear == RESET_HOLD + 6) |-> pulse_count == 1)
		else report_error("late reset pulse count is not one");
	a_rom: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(ref_val[rom_addr] === 1'b1) |-> rom_data == $past(ref_mem[rom_addr]))
		else report_error("rom_data differs from downloaded byte");
	a_ports: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n) |-> {landscape, input_0, input_1, input_2} == $past(exp_ports))
		else report_error("input ports or landscape mismatch");
	a_dip: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n) |-> input_3 == $past(ref_dip[0]))
		else report_error("input_3 differs from DIP byte 0");
	a_audio: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$past(rst_n) |-> {audio_signed, audio_l, audio_r} == $past(exp_audio))
		else report_error("audio output mismatch");

	// ========================================================================
	// Stimulus
	// ========================================================================

	task automatic write_byte(input logic [7:0] idx, input int addr, input logic [7:0] data);
		@(posedge clk_sys);
		ioctl_index <= idx;
		ioctl_addr <= IOCTL_ADDR_W'(addr);
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic wait_for_pulse_check();
		do @(posedge clk_sys); while (since_clear < RESET_HOLD + 8);
	endtask

	task automatic random_controls(input int cycles);
		repeat (cycles) begin
			@(posedge clk_sys);
			joystick_1 <= JOY_W'($random(seed));
			joystick_2 <= JOY_W'($random(seed));
			board_l <= sample_t'($random(seed));
			board_r <= sample_t'($random(seed));
			wav_pcm <= sample_t'($random(seed));
		end
	endtask

	initial begin
		rst_n = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		reset_request = 1'b0;
		joystick_1 = '0;
		joystick_2 = '0;
		rom_addr = '0;
		board_l = '0;
		board_r = '0;
		wav_pcm = '0;
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;

		// ROM download, with one byte past the end that must be dropped
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		for (int a = 0; a < ROM_BYTES; a++)
			write_byte(IDX_ROM, a, 8'($random(seed)));
		write_byte(IDX_ROM, 2 ** ROM_ADDR_W, 8'h5a);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		wait_for_pulse_check();

		repeat (2 * ROM_BYTES) begin
			@(posedge clk_sys);
			rom_addr <= ROM_ADDR_W'($random(seed) & (ROM_BYTES - 1));
		end

		// DIP bank; address 8 lies outside the bank and would alias byte 0
		@(posedge clk_sys);
		ioctl_index <= IDX_DIP;
		ioctl_download <= 1'b1;
		for (int a = 0; a < DIP_BANKS; a++)
			write_byte(IDX_DIP, a, 8'($random(seed)));
		write_byte(IDX_DIP, DIP_BANKS, ~ref_dip[0]);
		write_byte(IDX_DIP, 1, 8'h01);

		for (int g = 0; g < 4; g++) begin
			write_byte(IDX_GAME, 0, 8'(g));
			random_controls(40);
		end
		write_byte(IDX_GAME, 0, 8'd5);
		random_controls(20);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;

		// Both clamp limits under the Journey blend
		@(posedge clk_sys);
		board_l <= 16'sh7fff;
		board_r <= 16'sh8000;
		wav_pcm <= 16'sh7fff;
		@(posedge clk_sys);
		board_l <= 16'sh7f00;
		board_r <= 16'sh8000;
		wav_pcm <= 16'sh8000;
		repeat (2) @(posedge clk_sys);

		@(posedge clk_sys);
		reset_request <= 1'b1;
		repeat (3) @(posedge clk_sys);
		reset_request <= 1'b0;
		wait_for_pulse_check();
		repeat (2) @(posedge clk_sys);

		if (error_count == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1, "checks failed");
		end
	end

endmodule

// ==== compile.f ====
source/cabinet_pkg.sv
source/audio_pkg.sv
source/download_decoder.sv
source/program_rom.sv
source/reset_sequencer.sv
source/control_mapper.sv
source/audio_mixer.sv
source/mcr3_cabinet.sv
tb/tb_mcr3_cabinet.sv

// ==== Makefile ====
# Verilator build, run and lint for the cabinet logic

VERILATOR   ?= verilator
FILELIST    := compile.f
TOP         := tb_mcr3_cabinet
RTL_TOP     := mcr3_cabinet
SIM_FLAGS   := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only --timing
OBJ_DIR     := obj_dir
PASS_TEXT   := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) source/cabinet_pkg.sv \
		source/audio_pkg.sv source/download_decoder.sv source/program_rom.sv \
		source/reset_sequencer.sv source/control_mapper.sv source/audio_mixer.sv \
		source/mcr3_cabinet.sv
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
